//--- rtl/fcvt_defines.svh
// fcvt width and bias macros
`ifndef FCVT_DEFINES_SVH
`define FCVT_DEFINES_SVH

// fp32 encoding
`define FCVT_EXP_BITS 8
`define FCVT_MAN_BITS 23
`define FCVT_BIAS     127

// integer side
`define FCVT_INT_WIDTH 32

// internal mantissa holds the implicit bit or a whole integer
`define FCVT_MANT_WIDTH ((`FCVT_MAN_BITS + 1 > `FCVT_INT_WIDTH) ? \
                         (`FCVT_MAN_BITS + 1) : `FCVT_INT_WIDTH)

// signed, wide enough for the smallest subnormal exponent
`define FCVT_EXP_WIDTH 10

// renormalization shift amount
`define FCVT_LZC_WIDTH $clog2(`FCVT_MANT_WIDTH)

`endif

//--- rtl/fcvt_pkg.sv
// fcvt shared types

`include "fcvt_defines.svh"

package fcvt_pkg;

  // --------------------
  // vector types
  // --------------------
  typedef logic [`FCVT_INT_WIDTH-1:0]        word_t;    // operand or result
  typedef logic [`FCVT_MANT_WIDTH-1:0]       mant_t;    // normalized, leading one at msb
  typedef logic signed [`FCVT_EXP_WIDTH-1:0] exp_t;     // unbiased exponent
  typedef logic [`FCVT_LZC_WIDTH-1:0]        lzc_cnt_t;
  typedef logic [1:0]                        fflags_t;  // {NV, NX}

  // flag positions inside fflags_t
  localparam int unsigned FLAG_NV = 1;
  localparam int unsigned FLAG_NX = 0;

  // --------------------
  // encodings
  // --------------------
  typedef enum logic {
    F2I = 1'b0,
    I2F = 1'b1
  } cvt_op_e;

  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

endpackage

//--- rtl/fcvt_lzc.sv
// leading zero counter
`timescale 1ns/1ps

module fcvt_lzc (
  input  fcvt_pkg::mant_t    in_i,
  output fcvt_pkg::lzc_cnt_t cnt_o,
  output logic               empty_o
);

  logic [15:0] lvl16;
  logic [7:0]  lvl8;
  logic [3:0]  lvl4;
  logic [1:0]  lvl2;

  // halve the window at each level, keep the upper half if it has a one
  assign cnt_o[4] = ~|in_i[31:16];
  assign lvl16    = cnt_o[4] ? in_i[15:0] : in_i[31:16];
  assign cnt_o[3] = ~|lvl16[15:8];
  assign lvl8     = cnt_o[3] ? lvl16[7:0] : lvl16[15:8];
  assign cnt_o[2] = ~|lvl8[7:4];
  assign lvl4     = cnt_o[2] ? lvl8[3:0] : lvl8[7:4];
  assign cnt_o[1] = ~|lvl4[3:2];
  assign lvl2     = cnt_o[1] ? lvl4[1:0] : lvl4[3:2];
  assign cnt_o[0] = ~lvl2[1];

  assign empty_o = ~|in_i; // count is all ones then

endmodule

//--- rtl/fcvt_operand_prep.sv
// fcvt operand classify and normalize
`timescale 1ns/1ps

`include "fcvt_defines.svh"

module fcvt_operand_prep (
  input  fcvt_pkg::word_t   operand_i,
  input  fcvt_pkg::cvt_op_e op_i,
  input  logic              is_unsigned_i,
  output logic              sign_o,
  output fcvt_pkg::exp_t    exp_o,
  output fcvt_pkg::mant_t   mant_o,
  output logic              is_zero_o,
  output logic              is_inf_o,
  output logic              is_nan_o,
  output logic              is_snan_o
);

  // distance of the fp implicit bit below the internal msb
  localparam int unsigned MAN_OFFSET = `FCVT_MANT_WIDTH - 1 - `FCVT_MAN_BITS;

  logic src_is_int;

  assign src_is_int = (op_i == fcvt_pkg::I2F);

  // --------------------
  // float fields
  // --------------------
  logic [`FCVT_EXP_BITS-1:0] exp_field;
  logic [`FCVT_MAN_BITS-1:0] man_field;
  logic                      exp_is_zero;
  logic                      exp_all_ones;
  logic                      man_is_zero;
  fcvt_pkg::mant_t           fp_mant;

  assign exp_field    = operand_i[`FCVT_MAN_BITS +: `FCVT_EXP_BITS];
  assign man_field    = operand_i[`FCVT_MAN_BITS-1:0];
  assign exp_is_zero  = (exp_field == '0);
  assign exp_all_ones = (exp_field == '1);
  assign man_is_zero  = (man_field == '0);

  // implicit bit only for normals and zero padding on top
  assign fp_mant = fcvt_pkg::mant_t'({~exp_is_zero, man_field});

  // --------------------
  // integer magnitude
  // --------------------
  logic            int_sign;
  fcvt_pkg::word_t int_mag;

  assign int_sign = operand_i[`FCVT_INT_WIDTH-1] & ~is_unsigned_i;
  assign int_mag  = int_sign ? -operand_i : operand_i;

  // --------------------
  // normalization
  // --------------------
  fcvt_pkg::mant_t    encoded_mant;
  fcvt_pkg::lzc_cnt_t renorm_shamt;
  logic               mant_empty;
  fcvt_pkg::exp_t     fp_exp;
  fcvt_pkg::exp_t     int_exp;

  assign encoded_mant = src_is_int ? int_mag : fp_mant;

  fcvt_lzc i_lzc (
    .in_i    ( encoded_mant ),
    .cnt_o   ( renorm_shamt ),
    .empty_o ( mant_empty   )
  );

  assign mant_o = encoded_mant << renorm_shamt;

  // subnormals sit at exponent field one and the shift undoes the padding
  assign fp_exp = fcvt_pkg::exp_t'(exp_field) + fcvt_pkg::exp_t'(exp_is_zero)
                - fcvt_pkg::exp_t'(`FCVT_BIAS) - fcvt_pkg::exp_t'(renorm_shamt)
                + fcvt_pkg::exp_t'(MAN_OFFSET);

  assign int_exp = fcvt_pkg::exp_t'(`FCVT_MANT_WIDTH - 1) - fcvt_pkg::exp_t'(renorm_shamt);

  assign exp_o  = src_is_int ? int_exp : fp_exp;
  assign sign_o = src_is_int ? int_sign : operand_i[`FCVT_INT_WIDTH-1];

  // --------------------
  // class bits
  // --------------------
  assign is_zero_o = mant_empty; // float zero or zero integer
  assign is_inf_o  = ~src_is_int & exp_all_ones & man_is_zero;
  assign is_nan_o  = ~src_is_int & exp_all_ones & man_field[`FCVT_MAN_BITS-1]; // quiet bit set
  assign is_snan_o = ~src_is_int & exp_all_ones & ~man_is_zero
                   & ~man_field[`FCVT_MAN_BITS-1]; // quiet bit clear

endmodule

//--- rtl/fcvt_rounding.sv
// fcvt ieee rounding
`timescale 1ns/1ps

module fcvt_rounding (
  input  fcvt_pkg::word_t      abs_value_i,
  input  logic                 sign_i,
  input  logic [1:0]           round_sticky_i, // {round, sticky}
  input  fcvt_pkg::roundmode_e rnd_mode_i,
  output fcvt_pkg::word_t      abs_rounded_o,
  output logic                 exact_zero_o
);

  logic round_up;

  always_comb begin : round_decision
    unique case (rnd_mode_i)
      fcvt_pkg::RNE: begin
        // ties go to the even neighbour
        unique case (round_sticky_i)
          2'b00, 2'b01: round_up = 1'b0;
          2'b10:        round_up = abs_value_i[0];
          default:      round_up = 1'b1;
        endcase
      end
      fcvt_pkg::RTZ: round_up = 1'b0;
      fcvt_pkg::RDN: round_up = (|round_sticky_i) & sign_i;  // away from zero if negative
      fcvt_pkg::RUP: round_up = (|round_sticky_i) & ~sign_i; // away from zero if positive
      fcvt_pkg::RMM: round_up = round_sticky_i[1];           // ties away
      default:       round_up = 1'b0;
    endcase
  end

  // carry may ripple into the exponent field for floats
  assign abs_rounded_o = abs_value_i + fcvt_pkg::word_t'(round_up);

  assign exact_zero_o = (abs_rounded_o == '0);

endmodule

//--- rtl/fcvt_cast_core.sv
// fcvt cast and result select
`timescale 1ns/1ps

`include "fcvt_defines.svh"

module fcvt_cast_core (
  input  fcvt_pkg::cvt_op_e    op_i,
  input  logic                 is_unsigned_i,
  input  fcvt_pkg::roundmode_e rnd_mode_i,
  input  logic                 sign_i,
  input  logic                 is_zero_i,
  input  logic                 is_inf_i,
  input  logic                 is_nan_i,
  input  logic                 is_snan_i,
  input  fcvt_pkg::exp_t       exp_i,
  input  fcvt_pkg::mant_t      mant_i,
  output fcvt_pkg::word_t      result_o,
  output fcvt_pkg::fflags_t    fflags_o
);

  localparam int unsigned SHIFT_W = 2 * `FCVT_MANT_WIDTH + 1; // mantissa, round bit, sticky
  localparam int unsigned SHAMT_W = $clog2(`FCVT_INT_WIDTH + 2);

  logic dst_is_int;

  assign dst_is_int = (op_i == fcvt_pkg::F2I);

  // --------------------
  // float to int shift
  // --------------------
  logic [SHIFT_W-1:0]        preshift_mant;
  logic [SHIFT_W-1:0]        shifted_mant;
  logic [SHAMT_W-1:0]        int_shamt;
  logic                      int_min_exact;
  logic                      of_before_round;
  fcvt_pkg::word_t           int_abs;
  logic [1:0]                int_round_sticky;

  // -2^31 is the one signed value at exponent 31 that still fits
  assign int_min_exact = ~is_unsigned_i & sign_i
                       & (exp_i == fcvt_pkg::exp_t'(`FCVT_INT_WIDTH - 1))
                       & (mant_i == {1'b1, {(`FCVT_MANT_WIDTH-1){1'b0}}});

  assign preshift_mant = {mant_i, {(`FCVT_MANT_WIDTH+1){1'b0}}};

  always_comb begin : int_shift
    int_shamt       = SHAMT_W'(`FCVT_INT_WIDTH - 1 - exp_i);
    of_before_round = 1'b0;
    // unsigned range reaches one exponent higher
    if (exp_i >= fcvt_pkg::exp_t'(`FCVT_INT_WIDTH - 1) + fcvt_pkg::exp_t'(is_unsigned_i) &&
        !int_min_exact) begin
      int_shamt       = '0;
      of_before_round = 1'b1;
    end else if (exp_i < fcvt_pkg::exp_t'(-1)) begin
      int_shamt = SHAMT_W'(`FCVT_INT_WIDTH + 1); // everything lands in sticky
    end
  end

  assign shifted_mant = preshift_mant >> int_shamt;

  assign {int_abs, int_round_sticky[1]} = shifted_mant[SHIFT_W-1 -: `FCVT_INT_WIDTH+1];
  assign int_round_sticky[0] = |shifted_mant[SHIFT_W-`FCVT_INT_WIDTH-2:0];

  // --------------------
  // int to float placement
  // --------------------
  fcvt_pkg::exp_t  fp_biased_exp;
  fcvt_pkg::word_t fp_pre_round;
  logic [1:0]      fp_round_sticky;

  assign fp_biased_exp = exp_i + fcvt_pkg::exp_t'(`FCVT_BIAS); // never overflows fp32

  // drop the leading one, keep the stored mantissa bits
  assign fp_pre_round = {1'b0, fp_biased_exp[`FCVT_EXP_BITS-1:0],
                         mant_i[`FCVT_MANT_WIDTH-2 -: `FCVT_MAN_BITS]};

  assign fp_round_sticky[1] = mant_i[`FCVT_MANT_WIDTH-2-`FCVT_MAN_BITS];
  assign fp_round_sticky[0] = |mant_i[`FCVT_MANT_WIDTH-3-`FCVT_MAN_BITS:0];

  // --------------------
  // rounding
  // --------------------
  fcvt_pkg::word_t pre_round_abs;
  logic [1:0]      round_sticky;
  fcvt_pkg::word_t rounded_abs;
  logic            rounded_zero;

  assign pre_round_abs = dst_is_int ? int_abs : fp_pre_round;
  assign round_sticky  = dst_is_int ? int_round_sticky : fp_round_sticky;

  fcvt_rounding i_fcvt_rounding (
    .abs_value_i    ( pre_round_abs ),
    .sign_i         ( sign_i        ),
    .round_sticky_i ( round_sticky  ),
    .rnd_mode_i     ( rnd_mode_i    ),
    .abs_rounded_o  ( rounded_abs   ),
    .exact_zero_o   ( rounded_zero  )
  );

  fcvt_pkg::word_t int_regular;
  fcvt_pkg::word_t fp_regular;

  assign int_regular = sign_i ? -rounded_abs : rounded_abs; // back to two's complement
  assign fp_regular  = is_zero_i ? '0
                     : {sign_i, rounded_abs[`FCVT_INT_WIDTH-2:0]};

  // --------------------
  // int special cases
  // --------------------
  logic            nan_in;
  logic            int_is_special;
  fcvt_pkg::word_t int_special;

  assign nan_in = is_nan_i | is_snan_i; // both nan kinds saturate the same way

  assign int_is_special = nan_in | is_inf_i | of_before_round
                        | (sign_i & is_unsigned_i & ~rounded_zero);

  always_comb begin : int_saturate
    int_special = {is_unsigned_i, {(`FCVT_INT_WIDTH-1){1'b1}}}; // positive max
    if (sign_i && !nan_in) begin
      int_special = ~int_special; // -max or zero
    end
  end

  // --------------------
  // result select
  // --------------------
  always_comb begin : select_result
    fflags_o = '0;
    if (dst_is_int) begin
      if (int_is_special) begin
        result_o                     = int_special;
        fflags_o[fcvt_pkg::FLAG_NV]  = 1'b1;
      end else begin
        result_o                     = int_regular;
        fflags_o[fcvt_pkg::FLAG_NX]  = |int_round_sticky;
      end
    end else begin
      result_o                    = fp_regular;
      fflags_o[fcvt_pkg::FLAG_NX] = |fp_round_sticky; // zero mantissa gives no sticky
    end
  end

endmodule

//--- rtl/fcvt_pipe_stage.sv
// valid ready register stage
`timescale 1ns/1ps

module fcvt_pipe_stage #(
  parameter int unsigned Width = 32
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [Width-1:0] data_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [Width-1:0] data_o
);

  logic             valid_q;
  logic [Width-1:0] data_q;

  // free slot, or the held item leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i; // empties on output transfer without new input
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign data_o      = data_q;

endmodule

//--- rtl/fcvt_top.sv
// fcvt cast unit top
`timescale 1ns/1ps

module fcvt_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  fcvt_pkg::word_t      operand_i,
  input  fcvt_pkg::cvt_op_e    op_i,
  input  logic                 is_unsigned_i,
  input  fcvt_pkg::roundmode_e rnd_mode_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output fcvt_pkg::word_t      result_o,
  output fcvt_pkg::fflags_t    fflags_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  localparam int unsigned S1_W = 1 + $bits(fcvt_pkg::exp_t) + $bits(fcvt_pkg::mant_t) + 4
                               + $bits(fcvt_pkg::cvt_op_e) + 1 + $bits(fcvt_pkg::roundmode_e);
  localparam int unsigned S2_W = $bits(fcvt_pkg::word_t) + $bits(fcvt_pkg::fflags_t);

  // --------------------
  // prep and stage 1
  // --------------------
  logic            prep_sign, prep_zero, prep_inf, prep_nan, prep_snan;
  fcvt_pkg::exp_t  prep_exp;
  fcvt_pkg::mant_t prep_mant;

  fcvt_operand_prep i_operand_prep (
    .operand_i     ( operand_i     ),
    .op_i          ( op_i          ),
    .is_unsigned_i ( is_unsigned_i ),
    .sign_o        ( prep_sign     ),
    .exp_o         ( prep_exp      ),
    .mant_o        ( prep_mant     ),
    .is_zero_o     ( prep_zero     ),
    .is_inf_o      ( prep_inf      ),
    .is_nan_o      ( prep_nan      ),
    .is_snan_o     ( prep_snan     )
  );

  logic [S1_W-1:0] s1_d, s1_q;
  logic            s1_valid, s2_ready;

  assign s1_d = {prep_sign, prep_exp, prep_mant, prep_zero, prep_inf, prep_nan, prep_snan,
                 op_i, is_unsigned_i, rnd_mode_i};

  fcvt_pipe_stage #(.Width ( S1_W )) i_stage1 (
    .clk_i, .rst_n_i, .in_valid_i, .in_ready_o,
    .data_i      ( s1_d     ),
    .out_valid_o ( s1_valid ),
    .out_ready_i ( s2_ready ),
    .data_o      ( s1_q     )
  );

  // --------------------
  // cast and stage 2
  // --------------------
  logic            s1_sign, s1_zero, s1_inf, s1_nan, s1_snan, s1_op, s1_unsigned;
  fcvt_pkg::exp_t  s1_exp;
  fcvt_pkg::mant_t s1_mant;
  logic [2:0]      s1_rnd;
  fcvt_pkg::word_t   core_result;
  fcvt_pkg::fflags_t core_fflags;
  logic [S2_W-1:0]   s2_q;

  assign {s1_sign, s1_exp, s1_mant, s1_zero, s1_inf, s1_nan, s1_snan,
          s1_op, s1_unsigned, s1_rnd} = s1_q;

  fcvt_cast_core i_cast_core (
    .op_i          ( fcvt_pkg::cvt_op_e'(s1_op)     ),
    .is_unsigned_i ( s1_unsigned                    ),
    .rnd_mode_i    ( fcvt_pkg::roundmode_e'(s1_rnd) ),
    .sign_i        ( s1_sign                        ),
    .is_zero_i     ( s1_zero                        ),
    .is_inf_i      ( s1_inf                         ),
    .is_nan_i      ( s1_nan                         ),
    .is_snan_i     ( s1_snan                        ),
    .exp_i         ( s1_exp                         ),
    .mant_i        ( s1_mant                        ),
    .result_o      ( core_result                    ),
    .fflags_o      ( core_fflags                    )
  );

  fcvt_pipe_stage #(.Width ( S2_W )) i_stage2 (
    .clk_i, .rst_n_i, .out_valid_o, .out_ready_i,
    .in_valid_i  ( s1_valid                   ),
    .in_ready_o  ( s2_ready                   ),
    .data_i      ( {core_result, core_fflags} ),
    .data_o      ( s2_q                       )
  );

  assign {result_o, fflags_o} = s2_q;

endmodule

//--- testbench/fcvt_model.svh
// fcvt reference conversions
`ifndef FCVT_MODEL_SVH
`define FCVT_MODEL_SVH

// add one ulp or not, from the dropped bits
function automatic logic needs_increment(logic lsb, logic rbit, logic sticky, logic neg,
                                         fcvt_pkg::roundmode_e rm);
  case (rm)
    fcvt_pkg::RNE: return rbit & (sticky | lsb);
    fcvt_pkg::RTZ: return 1'b0;
    fcvt_pkg::RDN: return neg & (rbit | sticky);
    fcvt_pkg::RUP: return ~neg & (rbit | sticky);
    fcvt_pkg::RMM: return rbit;
    default:       return 1'b0;
  endcase
endfunction

// packed as {nv, nx, result}
function automatic logic [33:0] int_to_float(logic [31:0] value, logic uns,
                                             fcvt_pkg::roundmode_e rm);
  logic        neg;
  logic [63:0] mag;
  logic [63:0] kept;
  logic        rbit;
  logic        sticky;
  int          msb;
  int          sh;
  neg    = ~uns & value[31];
  mag    = {32'd0, neg ? -value : value};
  rbit   = 1'b0;
  sticky = 1'b0;
  if (mag == 64'd0) begin
    return 34'd0; // zero maps to +0
  end
  msb = 0;
  for (int b = 0; b < 32; b++) begin
    if (mag[b]) msb = b;
  end
  if (msb <= 23) begin
    kept = mag << (23 - msb); // fits the 24 bit significand
  end else begin
    sh     = msb - 23;
    kept   = mag >> sh;
    rbit   = mag[sh-1];
    sticky = (mag & ((64'd1 << (sh - 1)) - 64'd1)) != 64'd0;
    kept   = kept + needs_increment(kept[0], rbit, sticky, neg, rm);
    if (kept[24]) begin
      kept = kept >> 1; // rounded up to the next power of two
      msb  = msb + 1;
    end
  end
  return {1'b0, rbit | sticky, neg, 8'(msb + 127), kept[22:0]};
endfunction

function automatic logic [33:0] float_to_int(logic [31:0] value, logic uns,
                                             fcvt_pkg::roundmode_e rm);
  logic        neg;
  logic [7:0]  efield;
  logic [63:0] sig;
  logic [63:0] kept;
  logic        rbit;
  logic        sticky;
  logic        over;
  int          scale;
  neg    = value[31];
  efield = value[30:23];
  sig    = {40'd0, efield != 8'd0, value[22:0]};
  scale  = ((efield == 8'd0) ? 1 : int'(efield)) - 150; // value = sig * 2^scale
  rbit   = 1'b0;
  sticky = 1'b0;
  over   = 1'b0;
  kept   = 64'd0;
  if (efield == 8'hFF) begin
    over = 1'b1; // nan and infinity
  end else if (scale > 31) begin
    over = 1'b1;
  end else if (scale >= 0) begin
    kept = sig << scale;
  end else if (scale < -25) begin
    sticky = sig != 64'd0; // far below one half
  end else begin
    kept   = sig >> -scale;
    rbit   = sig[-scale-1];
    sticky = (sig & ((64'd1 << (-scale - 1)) - 64'd1)) != 64'd0;
  end
  kept = kept + needs_increment(kept[0], rbit, sticky, neg, rm);
  if (uns) begin
    over = over | (neg ? kept != 64'd0 : kept > 64'hFFFF_FFFF);
  end else begin
    over = over | (neg ? kept > 64'h8000_0000 : kept > 64'h7FFF_FFFF);
  end
  if (over) begin
    if (efield == 8'hFF && value[22:0] != 23'd0) begin
      return {2'b10, uns ? 32'hFFFF_FFFF : 32'h7FFF_FFFF};
    end
    if (uns) begin
      return {2'b10, neg ? 32'h0000_0000 : 32'hFFFF_FFFF};
    end
    return {2'b10, neg ? 32'h8000_0000 : 32'h7FFF_FFFF};
  end
  return {1'b0, rbit | sticky, neg ? -kept[31:0] : kept[31:0]};
endfunction

`endif

//--- testbench/fcvt_tb.sv
// fcvt cast unit testbench
`timescale 1ns/1ps

module fcvt_tb;

  `include "fcvt_model.svh"

  logic                 clk_i;
  logic                 rst_n_i;
  fcvt_pkg::word_t      operand_i;
  fcvt_pkg::cvt_op_e    op_i;
  logic                 is_unsigned_i;
  fcvt_pkg::roundmode_e rnd_mode_i;
  logic                 in_valid_i;
  logic                 in_ready_o;
  fcvt_pkg::word_t      result_o;
  fcvt_pkg::fflags_t    fflags_o;
  logic                 out_valid_o;
  logic                 out_ready_i;

  // items accepted by the DUT, oldest first
  logic [31:0] exp_result_q[$];
  logic [1:0]  exp_flags_q[$];
  string       name_q[$];
  int          accept_cyc_q[$];
  bit          timed_q[$];

  int cycle_cnt = 0;
  bit ready_random;
  bit timed_phase; // out_ready held high, latency checked

  fcvt_top dut (
    .clk_i, .rst_n_i, .operand_i, .op_i, .is_unsigned_i, .rnd_mode_i,
    .in_valid_i, .in_ready_o, .result_o, .fflags_o, .out_valid_o, .out_ready_i
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  always @(posedge clk_i) begin : drive_out_ready
    #1;
    out_ready_i = ready_random ? (($urandom % 4) != 0) : 1'b1; // low about a quarter of cycles
  end

  // --------------------
  // checking helpers
  // --------------------
  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  always @(negedge clk_i) begin : collect_outputs
    string name;
    int    accepted;
    bit    timed;
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (exp_result_q.size() == 0) begin
        stop_with_failure("an output appeared with no accepted input left");
      end else begin
        name     = name_q.pop_front();
        accepted = accept_cyc_q.pop_front();
        timed    = timed_q.pop_front();
        check_value({name, " result"}, exp_result_q.pop_front(), result_o);
        check_value({name, " flags"}, 32'(exp_flags_q.pop_front()), 32'(fflags_o));
        if (timed) check_value({name, " latency"}, 2, cycle_cnt - accepted);
      end
    end
  end

  // --------------------
  // stimulus
  // --------------------
  // entered 1 ns after a rising edge, leaves at the same point
  task automatic send_item(string name, logic [31:0] operand, fcvt_pkg::cvt_op_e op,
                           logic uns, fcvt_pkg::roundmode_e rm);
    logic [33:0] expected;
    int          waited;
    expected = (op == fcvt_pkg::I2F) ? int_to_float(operand, uns, rm)
                                     : float_to_int(operand, uns, rm);
    operand_i     = operand;
    op_i          = op;
    is_unsigned_i = uns;
    rnd_mode_i    = rm;
    in_valid_i    = 1'b1;
    waited        = 0;
    @(negedge clk_i);
    if (timed_phase) check_value({name, " in_ready"}, 1, in_ready_o);
    while (!in_ready_o) begin
      if (waited == 100) stop_with_failure("the DUT did not accept an input in time");
      waited++;
      @(negedge clk_i);
    end
    exp_result_q.push_back(expected[31:0]);
    exp_flags_q.push_back(expected[33:32]);
    name_q.push_back(name);
    accept_cyc_q.push_back(cycle_cnt); // transfer on the next edge
    timed_q.push_back(timed_phase);
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  task automatic send_random(string name, int kind, int idx);
    logic [31:0]          operand;
    fcvt_pkg::cvt_op_e    op;
    logic                 uns;
    logic                 sgn;
    fcvt_pkg::roundmode_e rm;
    uns = 1'($urandom);
    sgn = 1'($urandom);
    rm  = fcvt_pkg::roundmode_e'(idx % 5);
    op  = (kind <= 2) ? fcvt_pkg::I2F : fcvt_pkg::F2I;
    case (kind)
      1: begin // exact integers
        case ($urandom % 4)
          0:       operand = 32'd0;
          1:       operand = $urandom % 16;
          default: operand = $urandom % 32'h0100_0000;
        endcase
        if (!uns && sgn) operand = -operand;
      end
      2: begin // more than 24 significant bits
        operand = ($urandom & 32'h7FFF_FFFF) | 32'h0200_0000;
        if (!uns && sgn) operand = -operand;
        else if (uns && sgn) operand[31] = 1'b1;
      end
      3: begin
        if (uns) sgn = 1'b0;
        case ($urandom % 4)
          0:       operand = {sgn, 8'd0, 23'($urandom)}; // subnormal
          1:       operand = {sgn, 8'(100 + $urandom % 27), 23'($urandom)};
          default: operand = {sgn, 8'(127 + $urandom % 31), 23'($urandom)};
        endcase
      end
      default: begin
        case ($urandom % 5)
          0: operand = {sgn, 8'hFF, 1'b1, 22'($urandom)};
          1: operand = {sgn, 8'hFF, 1'b0, 22'($urandom % 32'h3F_FFFF) + 22'd1};
          2: operand = {sgn, 8'hFF, 23'd0};
          3: operand = {sgn, 8'(158 + $urandom % 97), 23'($urandom)};
          default: begin // negative to unsigned
            uns     = 1'b1;
            operand = {1'b1, 8'(127 + $urandom % 24), 23'($urandom)};
          end
        endcase
      end
    endcase
    send_item(name, operand, op, uns, rm);
  endtask

  // kind 0 mixes all the others
  task automatic run_phase(string name, int kind, int count);
    for (int i = 0; i < count; i++) begin
      send_random(name, (kind == 0) ? 1 + int'($urandom % 4) : kind, i);
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (exp_result_q.size() != 0) begin
      if (waited == 200) stop_with_failure("the pipeline did not drain in time");
      waited++;
      @(posedge clk_i);
      #1;
    end
  endtask

  initial begin : drive_stimulus
    void'($urandom(78));
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    operand_i     = '0;
    op_i          = fcvt_pkg::F2I;
    is_unsigned_i = 1'b0;
    rnd_mode_i    = fcvt_pkg::RNE;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    ready_random  = 1'b0;
    timed_phase   = 1'b0;
    repeat (4) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("reset out_valid", 0, out_valid_o);
    check_value("reset in_ready", 1, in_ready_o);
    @(posedge clk_i);
    #1;
    ready_random = 1'b1;
    run_phase("i2f_exact", 1, 200);
    run_phase("i2f_round", 2, 300);
    run_phase("f2i_range", 3, 400);
    run_phase("f2i_special", 4, 200);
    ready_random = 1'b0;
    wait_for_drain();
    repeat (2) @(posedge clk_i);
    #1;
    timed_phase = 1'b1;
    run_phase("back_to_back", 0, 200);
    wait_for_drain();
    $display("Test OK");
    $finish;
  end

endmodule

//--- fcvt_top.f
+incdir+rtl
+incdir+testbench
rtl/fcvt_pkg.sv
rtl/fcvt_lzc.sv
rtl/fcvt_operand_prep.sv
rtl/fcvt_rounding.sv
rtl/fcvt_cast_core.sv
rtl/fcvt_pipe_stage.sv
rtl/fcvt_top.sv
testbench/fcvt_tb.sv

//--- Bender.yml
package:
  name: fcvt

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fcvt_pkg.sv
      - rtl/fcvt_lzc.sv
      - rtl/fcvt_operand_prep.sv
      - rtl/fcvt_rounding.sv
      - rtl/fcvt_cast_core.sv
      - rtl/fcvt_pipe_stage.sv
      - rtl/fcvt_top.sv
  - target: test
    include_dirs:
      - rtl
      - testbench
    files:
      - testbench/fcvt_tb.sv
